// ==== src.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/fu_pkg.sv
hdl/operand_select.sv
hdl/alu_cond.sv
hdl/mult_impl.sv
hdl/fu.sv
test/fu_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f --top-module fu_tb \
    -o fu_sim \
    && ./obj_dir/fu_sim \
    || { echo "simulation returned a failing status"; exit 1; }

// ==== test/fu_tb.sv ====
`default_nettype none
`include "fu_config.svh"

module fu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ALU      = `NUM_FU_ALU;
    localparam int NUM_MULT     = `NUM_FU_MULT;
    localparam int STAGES       = `MULT_STAGES;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 400;
    localparam int N_MULT       = 60;
    localparam int N_STALL      = 300;
    localparam int N_TXN        = RESET_CYCLES + N_ALU + N_MULT + N_STALL + 8;

    typedef struct packed {
        fu_pkg::fu_basic_t basic;
        int                age; // avail edges since issue
    } inflight_t;

    logic                              clock;
    logic                              arst_n;
    logic                              squash;
    fu_pkg::fu_packet_t [NUM_ALU-1:0]  alu_pkt;
    fu_pkg::fu_packet_t [NUM_MULT-1:0] mult_pkt;
    logic               [NUM_MULT-1:0] mult_avail;
    fu_pkg::fu_state_t                 state;
    fu_pkg::fu_rob_t    [NUM_ALU-1:0]  rob;

    fu_pkg::fu_alu_out_t [NUM_ALU-1:0]  exp_alu;
    fu_pkg::fu_rob_t     [NUM_ALU-1:0]  exp_rob;
    logic                [NUM_MULT-1:0] exp_done;
    fu_pkg::fu_basic_t   [NUM_MULT-1:0] exp_mout;
    inflight_t                          pend [NUM_MULT][$]; // oldest first

    fu i_dut (
        .clock           (clock),
        .arst_n          (arst_n),
        .squash          (squash),
        .fu_alu_packet   (alu_pkt),
        .fu_mult_packet  (mult_pkt),
        .mult_avail      (mult_avail),
        .fu_state_packet (state),
        .cond_rob_packet (rob)
    );

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic flag_value_error(input string name, input logic [127:0] dut,
                                    input logic [127:0] exp);
        $display("Mismatch %s: dut 0x%0h, expected 0x%0h", name, dut, exp);
        abort_run();
    endtask

    function automatic isa_pkg::data_t opa_ref(input fu_pkg::fu_packet_t p);
        case (p.opa_select)
            isa_pkg::OPA_IS_PC:   return p.pc;
            isa_pkg::OPA_IS_ZERO: return 32'd0;
            default:              return p.op1;
        endcase
    endfunction

    // immediates rebuilt from raw instruction bits
    function automatic isa_pkg::data_t opb_ref(input fu_pkg::fu_packet_t p);
        logic [31:0] w;
        w = p.inst;
        case (p.opb_select)
            isa_pkg::OPB_IS_I_IMM: return {{20{w[31]}}, w[31:20]};
            isa_pkg::OPB_IS_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
            isa_pkg::OPB_IS_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            isa_pkg::OPB_IS_U_IMM: return {w[31:12], 12'd0};
            isa_pkg::OPB_IS_J_IMM: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:               return p.op2;
        endcase
    endfunction

    function automatic isa_pkg::data_t alu_ref(input isa_pkg::alu_func_e f,
                                               input isa_pkg::data_t a, input isa_pkg::data_t b);
        case (f)
            isa_pkg::ALU_SUB:  return a - b;
            isa_pkg::ALU_AND:  return a & b;
            isa_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            isa_pkg::ALU_OR:   return a | b;
            isa_pkg::ALU_XOR:  return a ^ b;
            isa_pkg::ALU_SRL:  return a >> b[4:0];
            isa_pkg::ALU_SLL:  return a << b[4:0];
            isa_pkg::ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
            default:           return a + b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input isa_pkg::data_t a,
                                        input isa_pkg::data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return !($signed(a) < $signed(b));
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // full 64-bit product of the extended operands
    function automatic isa_pkg::data_t mult_ref(input isa_pkg::mult_func_e f,
                                                input isa_pkg::data_t a, input isa_pkg::data_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        ea   = (f == isa_pkg::MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
        eb   = (f == isa_pkg::MUL || f == isa_pkg::MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = ea * eb;
        return (f == isa_pkg::MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic isa_pkg::data_t pick_operand();
        case ($urandom_range(5))
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0000;
            4:       return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic fu_pkg::fu_packet_t random_alu_packet();
        fu_pkg::fu_packet_t p;
        logic [2:0]         f3;
        p          = '0;
        p.valid    = 1'b1;
        p.pc       = $urandom & 32'hffff_fffc;
        p.inst     = $urandom;
        p.op1      = pick_operand();
        p.op2      = pick_operand();
        p.robn     = fu_pkg::robn_t'($urandom);
        p.dest_prn = fu_pkg::prn_t'($urandom);
        case ($urandom_range(2))
            0: begin
                p.alu_func   = isa_pkg::alu_func_e'(4'($urandom_range(9)));
                p.opa_select = isa_pkg::opa_sel_e'(2'($urandom_range(2)));
                p.opb_select = isa_pkg::opb_sel_e'(3'($urandom_range(5)));
            end
            1: begin
                f3               = 3'($urandom_range(5));
                p.inst.b.funct3  = (f3 > 3'd1) ? f3 + 3'd2 : f3; // skip 010 and 011
                p.cond_branch    = 1'b1;
                p.opa_select     = isa_pkg::OPA_IS_PC;
                p.opb_select     = isa_pkg::OPB_IS_B_IMM;
            end
            default: begin
                p.uncond_branch = 1'b1;
                if ($urandom_range(1) == 1) begin
                    p.opa_select = isa_pkg::OPA_IS_PC; // jal
                    p.opb_select = isa_pkg::OPB_IS_J_IMM;
                end else begin
                    p.opb_select = isa_pkg::OPB_IS_I_IMM; // jalr
                end
            end
        endcase
        return p;
    endfunction

    function automatic fu_pkg::fu_packet_t random_mult_packet(input logic valid);
        fu_pkg::fu_packet_t p;
        p           = '0;
        p.valid     = valid;
        p.op1       = pick_operand();
        p.op2       = pick_operand();
        p.mult_func = isa_pkg::mult_func_e'(2'($urandom_range(3)));
        p.robn      = fu_pkg::robn_t'($urandom);
        p.dest_prn  = fu_pkg::prn_t'($urandom);
        return p;
    endfunction

    function automatic int in_flight();
        int n;
        n = 0;
        for (int m = 0; m < NUM_MULT; m++) begin
            n += pend[m].size();
        end
        return n;
    endfunction

    always_comb begin
        for (int a = 0; a < NUM_ALU; a++) begin
            exp_alu[a].basic.result   = alu_ref(alu_pkt[a].alu_func, opa_ref(alu_pkt[a]),
                                                opb_ref(alu_pkt[a]));
            exp_alu[a].basic.robn     = alu_pkt[a].robn;
            exp_alu[a].basic.dest_prn = alu_pkt[a].dest_prn;
            exp_alu[a].npc            = alu_pkt[a].pc + 32'd4;
            exp_alu[a].take_branch    = alu_pkt[a].uncond_branch || (alu_pkt[a].cond_branch
                && branch_ref(alu_pkt[a].inst.b.funct3, alu_pkt[a].op1, alu_pkt[a].op2));
            exp_alu[a].cond_branch    = alu_pkt[a].cond_branch;
            exp_alu[a].uncond_branch  = alu_pkt[a].uncond_branch;
            exp_rob[a].robn           = alu_pkt[a].robn;
            exp_rob[a].executed       = alu_pkt[a].valid && alu_pkt[a].cond_branch;
            exp_rob[a].branch_taken   = exp_alu[a].take_branch;
            exp_rob[a].target_addr    = exp_alu[a].basic.result;
        end
    end

    // multiplier model reads its inputs before the edge updates them
    always @(posedge clock or negedge arst_n) begin : mult_model
        inflight_t e;
        for (int m = 0; m < NUM_MULT; m++) begin
            if (!arst_n) begin
                pend[m].delete();
                exp_done[m] <= 1'b0;
            end else if (squash) begin
                pend[m].delete();
                exp_done[m] <= 1'b0;
            end else if (mult_avail[m]) begin
                if (pend[m].size() > 0 && pend[m][0].age == STAGES) begin
                    void'(pend[m].pop_front()); // taken by the bus
                end
                for (int k = 0; k < pend[m].size(); k++) begin
                    pend[m][k].age = pend[m][k].age + 1;
                end
                if (mult_pkt[m].valid) begin
                    e.basic.result   = mult_ref(mult_pkt[m].mult_func, opa_ref(mult_pkt[m]),
                                                opb_ref(mult_pkt[m]));
                    e.basic.robn     = mult_pkt[m].robn;
                    e.basic.dest_prn = mult_pkt[m].dest_prn;
                    e.age            = 0;
                    pend[m].push_back(e);
                end
                if (pend[m].size() > 0 && pend[m][0].age == STAGES) begin
                    exp_done[m] <= 1'b1;
                    exp_mout[m] <= pend[m][0].basic;
                end else begin
                    exp_done[m] <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clock)
        !arst_n |-> !(|state.mult_prepared) && !(|state.alu_prepared))
    else begin
        $display("prepared or done output high during reset");
        abort_run();
    end

    for (genvar a = 0; a < NUM_ALU; a++) begin : g_alu_chk
        assert property (@(posedge clock) state.alu_prepared[a] == alu_pkt[a].valid)
        else flag_value_error($sformatf("alu_prepared[%0d]", a),
                              128'($sampled(state.alu_prepared[a])),
                              128'($sampled(alu_pkt[a].valid)));

        assert property (@(posedge clock)
            alu_pkt[a].valid |-> state.alu_packet[a].basic.result == exp_alu[a].basic.result)
        else flag_value_error($sformatf("alu_packet[%0d].basic.result", a),
                              128'($sampled(state.alu_packet[a].basic.result)),
                              128'($sampled(exp_alu[a].basic.result)));

        assert property (@(posedge clock) alu_pkt[a].valid |-> state.alu_packet[a] == exp_alu[a])
        else flag_value_error($sformatf("alu_packet[%0d]", a),
                              128'($sampled(state.alu_packet[a])), 128'($sampled(exp_alu[a])));

        assert property (@(posedge clock) rob[a] == exp_rob[a])
        else flag_value_error($sformatf("cond_rob_packet[%0d]", a),
                              128'($sampled(rob[a])), 128'($sampled(exp_rob[a])));
    end

    for (genvar m = 0; m < NUM_MULT; m++) begin : g_mult_chk
        assert property (@(posedge clock) disable iff (!arst_n)
            state.mult_prepared[m] == exp_done[m])
        else flag_value_error($sformatf("mult_prepared[%0d]", m),
                              128'($sampled(state.mult_prepared[m])),
                              128'($sampled(exp_done[m])));

        assert property (@(posedge clock) disable iff (!arst_n)
            exp_done[m] |-> state.mult_packet[m] == exp_mout[m])
        else flag_value_error($sformatf("mult_packet[%0d]", m),
                              128'($sampled(state.mult_packet[m])), 128'($sampled(exp_mout[m])));
    end

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin : watchdog
        #(N_TXN * 40 * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d cycles", N_TXN * 40);
        abort_run();
    end

    initial begin : stimulus
        int   stall_left [NUM_MULT];
        logic go;
        void'($urandom(81));
        arst_n     = 1'b0;
        squash     = 1'b0;
        alu_pkt    = '0;
        mult_pkt   = '0;
        mult_avail = '1;
        stall_left = '{default: 0};
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
        repeat (2) @(posedge clock);

        repeat (N_ALU) begin
            @(posedge clock);
            for (int a = 0; a < NUM_ALU; a++) begin
                alu_pkt[a] <= random_alu_packet();
            end
        end
        @(posedge clock);
        alu_pkt <= '0;

        // back to back issue on every multiplier
        repeat (N_MULT) begin
            @(posedge clock);
            for (int m = 0; m < NUM_MULT; m++) begin
                mult_pkt[m] <= random_mult_packet(1'b1);
            end
        end

        // completion bus refuses for random stretches
        repeat (N_STALL) begin
            @(posedge clock);
            for (int m = 0; m < NUM_MULT; m++) begin
                if (stall_left[m] == 0 && $urandom_range(3) == 0) begin
                    stall_left[m] = $urandom_range(8, 1);
                end
                go = stall_left[m] == 0;
                if (!go) begin
                    stall_left[m]--;
                end
                mult_avail[m] <= go;
                mult_pkt[m]   <= random_mult_packet(go && $urandom_range(1) == 1);
            end
        end
        @(posedge clock);
        mult_avail <= '1;
        mult_pkt   <= '0;
        @(posedge clock);
        while (in_flight() != 0) @(posedge clock);

        repeat (3) begin
            @(posedge clock);
            for (int m = 0; m < NUM_MULT; m++) begin
                mult_pkt[m] <= random_mult_packet(1'b1);
            end
        end
        @(posedge clock);
        mult_pkt <= '0;
        squash   <= 1'b1;
        @(posedge clock);
        squash <= 1'b0;
        repeat (2 * STAGES) @(posedge clock);
        for (int m = 0; m < NUM_MULT; m++) begin
            mult_pkt[m] <= random_mult_packet(1'b1); // fresh issue after the squash
        end
        @(posedge clock);
        mult_pkt <= '0;
        @(posedge clock);
        while (in_flight() != 0) @(posedge clock);
        repeat (2) @(posedge clock);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/fu.sv ====
`default_nettype none
`include "fu_config.svh"

module fu (
    input  wire logic                                  clock,
    input  wire logic                                  arst_n,
    input  wire logic                                  squash,
    input  wire fu_pkg::fu_packet_t [`NUM_FU_ALU-1:0]  fu_alu_packet,
    input  wire fu_pkg::fu_packet_t [`NUM_FU_MULT-1:0] fu_mult_packet,
    input  wire logic               [`NUM_FU_MULT-1:0] mult_avail,
    output fu_pkg::fu_state_t                          fu_state_packet,
    output fu_pkg::fu_rob_t         [`NUM_FU_ALU-1:0]  cond_rob_packet
);
    logic                [`NUM_FU_ALU-1:0]  alu_prepared;
    fu_pkg::fu_alu_out_t [`NUM_FU_ALU-1:0]  alu_out;
    logic                [`NUM_FU_MULT-1:0] mult_done;
    fu_pkg::fu_basic_t   [`NUM_FU_MULT-1:0] mult_out;

    for (genvar i = 0; i < `NUM_FU_ALU; i++) begin : g_alu
        alu_cond i_alu_cond (
            .pkt      (fu_alu_packet[i]),
            .prepared (alu_prepared[i]),
            .out      (alu_out[i])
        );
    end

    for (genvar i = 0; i < `NUM_FU_MULT; i++) begin : g_mult
        mult_impl i_mult_impl (
            .clock  (clock),
            .arst_n (arst_n),
            .squash (squash),
            .pkt    (fu_mult_packet[i]),
            .avail  (mult_avail[i]),
            .done   (mult_done[i]),
            .out    (mult_out[i])
        );
    end

    always_comb begin
        fu_state_packet.alu_prepared  = alu_prepared;
        fu_state_packet.alu_packet    = alu_out;
        fu_state_packet.mult_prepared = mult_done;
        fu_state_packet.mult_packet   = mult_out;
        // only conditional branches resolve at the rob from here
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            cond_rob_packet[i].robn         = alu_out[i].basic.robn;
            cond_rob_packet[i].executed     = alu_prepared[i] && alu_out[i].cond_branch;
            cond_rob_packet[i].branch_taken = alu_out[i].take_branch;
            cond_rob_packet[i].target_addr  = alu_out[i].basic.result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mult_impl.sv ====
`default_nettype none
`include "fu_config.svh"

module mult_impl (
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire logic               squash,
    input  wire fu_pkg::fu_packet_t pkt,
    input  wire logic               avail,
    output logic                    done,
    output fu_pkg::fu_basic_t       out
);
    localparam int STAGES = `MULT_STAGES;
    localparam int CHUNK  = 32 / STAGES; // multiplier bits retired per stage

    typedef struct packed {
        isa_pkg::mult_func_e func;
        fu_pkg::robn_t       robn;
        fu_pkg::prn_t        dest_prn;
        logic [63:0]         prod;
        logic [63:0]         mcand;
        logic [31:0]         mplier;
    } stage_t;

    isa_pkg::data_t      opa;
    isa_pkg::data_t      opb;
    logic                a_signed;
    logic                b_signed;
    stage_t              first;
    stage_t              last;
    logic   [STAGES-1:0] stage_valid; // bit 0 is the newest
    stage_t [STAGES-1:0] stage_q;

    function automatic stage_t step(input stage_t s);
        stage_t n;
        n        = s;
        n.prod   = s.prod + s.mcand * 64'(s.mplier[CHUNK-1:0]);
        n.mcand  = s.mcand << CHUNK;
        n.mplier = s.mplier >> CHUNK;
        return n;
    endfunction

    operand_select i_operand_select (
        .pkt (pkt),
        .opa (opa),
        .opb (opb)
    );

    always_comb begin
        a_signed       = pkt.mult_func != isa_pkg::MULHU;
        b_signed       = pkt.mult_func inside {isa_pkg::MUL, isa_pkg::MULH};
        first.func     = pkt.mult_func;
        first.robn     = pkt.robn;
        first.dest_prn = pkt.dest_prn;
        first.mcand    = {{32{a_signed & opa[31]}}, opa};
        first.mplier   = opb;
        // a negative signed multiplier is its unsigned value minus 2^32
        first.prod     = (b_signed && opb[31]) ? {32'd0 - opa, 32'd0} : 64'd0;
    end

    assign last = step(stage_q[STAGES-1]);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= '0;
            done        <= 1'b0;
        end else if (squash) begin
            stage_valid <= '0;
            done        <= 1'b0;
        end else if (avail) begin
            stage_valid <= STAGES'({stage_valid, pkt.valid});
            done        <= stage_valid[STAGES-1];
        end
    end

    // whole pipe advances together, so a stall holds every stage
    always_ff @(posedge clock) begin
        if (avail) begin
            stage_q[0] <= first;
            for (int k = 1; k < STAGES; k++) begin
                stage_q[k] <= step(stage_q[k-1]);
            end
            out.result   <= (last.func == isa_pkg::MUL) ? last.prod[31:0] : last.prod[63:32];
            out.robn     <= last.robn;
            out.dest_prn <= last.dest_prn;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        !avail && !squash |=> $stable(done) && (!done || $stable(out)))
    else $error("multiplier output moved while stalled");

    assert property (@(posedge clock) disable iff (!arst_n) squash |=> !done)
    else $error("multiplier done right after squash");

endmodule

`default_nettype wire

// ==== hdl/alu_cond.sv ====
`default_nettype none

module alu (
    input  wire isa_pkg::data_t     opa,
    input  wire isa_pkg::data_t     opb,
    input  wire isa_pkg::alu_func_e func,
    output isa_pkg::data_t          result
);
    always_comb begin
        case (func)
            isa_pkg::ALU_ADD:  result = opa + opb;
            isa_pkg::ALU_SUB:  result = opa - opb;
            isa_pkg::ALU_AND:  result = opa & opb;
            isa_pkg::ALU_SLT:  result = {31'd0, $signed(opa) < $signed(opb)};
            isa_pkg::ALU_SLTU: result = {31'd0, opa < opb};
            isa_pkg::ALU_OR:   result = opa | opb;
            isa_pkg::ALU_XOR:  result = opa ^ opb;
            isa_pkg::ALU_SRL:  result = opa >> opb[4:0];
            isa_pkg::ALU_SLL:  result = opa << opb[4:0];
            isa_pkg::ALU_SRA:  result = $unsigned($signed(opa) >>> opb[4:0]);
            default:           result = 32'hbadc0de0; // six unused codes
        endcase
    end

endmodule

module conditional_branch (
    input  wire logic [2:0]     func,
    input  wire isa_pkg::data_t rs1,
    input  wire isa_pkg::data_t rs2,
    output logic                take
);
    always_comb begin
        case (func)
            3'b000:  take = rs1 == rs2;                   // beq
            3'b001:  take = rs1 != rs2;                   // bne
            3'b100:  take = $signed(rs1) < $signed(rs2);  // blt
            3'b101:  take = $signed(rs1) >= $signed(rs2); // bge
            3'b110:  take = rs1 < rs2;                    // bltu
            3'b111:  take = rs1 >= rs2;                   // bgeu
            default: take = 1'b0;
        endcase
    end

endmodule

module alu_cond (
    input  wire fu_pkg::fu_packet_t pkt,
    output logic                    prepared,
    output fu_pkg::fu_alu_out_t     out
);
    isa_pkg::data_t opa;
    isa_pkg::data_t opb;
    isa_pkg::data_t alu_result;
    logic           cond_take;

    operand_select i_operand_select (
        .pkt (pkt),
        .opa (opa),
        .opb (opb)
    );

    alu i_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (pkt.alu_func),
        .result (alu_result)
    );

    // condition compares the raw registers, the alu computes the target
    conditional_branch i_conditional_branch (
        .func (pkt.inst.b.funct3),
        .rs1  (pkt.op1),
        .rs2  (pkt.op2),
        .take (cond_take)
    );

    assign prepared = pkt.valid; // zero latency

    always_comb begin
        out.basic.result   = alu_result;
        out.basic.robn     = pkt.robn;
        out.basic.dest_prn = pkt.dest_prn;
        out.npc            = pkt.pc + 32'd4;
        out.take_branch    = pkt.uncond_branch || (pkt.cond_branch && cond_take);
        out.cond_branch    = pkt.cond_branch;
        out.uncond_branch  = pkt.uncond_branch;
    end

    always_comb begin
        if (prepared) begin
            assert (!$isunknown(out.basic.result))
            else $error("alu unit prepared with an unknown result");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/operand_select.sv ====
`default_nettype none

module operand_select (
    input  wire fu_pkg::fu_packet_t pkt,
    output isa_pkg::data_t          opa,
    output isa_pkg::data_t          opb
);
    localparam isa_pkg::data_t OPA_POISON = 32'hdead0a0a;
    localparam isa_pkg::data_t OPB_POISON = 32'hdead0b0b;

    isa_pkg::inst_t inst;

    assign inst = pkt.inst;

    always_comb begin
        case (pkt.opa_select)
            isa_pkg::OPA_IS_RS1:  opa = pkt.op1;
            isa_pkg::OPA_IS_PC:   opa = pkt.pc;
            isa_pkg::OPA_IS_ZERO: opa = '0;
            default:              opa = OPA_POISON;
        endcase
    end

    // immediates are sign extended from the top instruction bit
    always_comb begin
        case (pkt.opb_select)
            isa_pkg::OPB_IS_RS2:   opb = pkt.op2;
            isa_pkg::OPB_IS_I_IMM: opb = {{20{inst.i.imm[11]}}, inst.i.imm};
            isa_pkg::OPB_IS_S_IMM: opb = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            isa_pkg::OPB_IS_B_IMM: begin
                opb = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            end
            isa_pkg::OPB_IS_U_IMM: opb = {inst.u.imm, 12'd0};
            isa_pkg::OPB_IS_J_IMM: begin
                opb = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
            end
            default:               opb = OPB_POISON;
        endcase
    end

    // scheduler must never issue an unused select code
    always_comb begin
        if (pkt.valid) begin
            assert (pkt.opa_select inside {isa_pkg::OPA_IS_RS1, isa_pkg::OPA_IS_PC,
                                           isa_pkg::OPA_IS_ZERO}
                    && pkt.opb_select <= isa_pkg::OPB_IS_J_IMM)
            else $error("illegal operand select on a valid packet");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fu_pkg.sv ====
`default_nettype none
`include "fu_config.svh"

package fu_pkg;

    typedef logic [`ROB_IDX_W-1:0] robn_t;
    typedef logic [`PRN_W-1:0]     prn_t;

    // issue packet from a reservation station slot
    typedef struct packed {
        logic                valid;
        isa_pkg::data_t      pc;
        isa_pkg::inst_t      inst;
        isa_pkg::data_t      op1;
        isa_pkg::data_t      op2;
        isa_pkg::opa_sel_e   opa_select;
        isa_pkg::opb_sel_e   opb_select;
        isa_pkg::alu_func_e  alu_func;
        isa_pkg::mult_func_e mult_func;
        logic                cond_branch;
        logic                uncond_branch;
        robn_t               robn;
        prn_t                dest_prn;
    } fu_packet_t;

    typedef struct packed {
        isa_pkg::data_t result;
        robn_t          robn;
        prn_t           dest_prn;
    } fu_basic_t;

    typedef struct packed {
        fu_basic_t      basic;
        isa_pkg::data_t npc;
        logic           take_branch;
        logic           cond_branch;
        logic           uncond_branch;
    } fu_alu_out_t;

    // everything the completion bus sees
    typedef struct packed {
        logic        [`NUM_FU_ALU-1:0]  alu_prepared;
        fu_alu_out_t [`NUM_FU_ALU-1:0]  alu_packet;
        logic        [`NUM_FU_MULT-1:0] mult_prepared;
        fu_basic_t   [`NUM_FU_MULT-1:0] mult_packet;
    } fu_state_t;

    typedef struct packed {
        robn_t          robn;
        logic           executed;
        logic           branch_taken;
        isa_pkg::data_t target_addr;
    } fu_rob_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] data_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, decoded per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_OR,
        ALU_XOR,
        ALU_SRL,
        ALU_SLL,
        ALU_SRA
    } alu_func_e;

    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mult_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

endpackage

`default_nettype wire

// ==== hdl/fu_config.svh ====
`ifndef FU_CONFIG_SVH
`define FU_CONFIG_SVH

// unit counts per functional unit type
`define NUM_FU_ALU  2
`define NUM_FU_MULT 2

// multiplier pipeline depth of 1, 2, 4 or 8
`define MULT_STAGES 4

// tag widths
`define ROB_IDX_W 5
`define PRN_W     6

`endif
